// File: hw/apb_sub_defines.svh
// Bus map and widths shared by the RTL and the testbench
// Windows are contiguous, equal sized, and must end below 4 GiB
// Lane order is picked by value, 1'b0 little-endian or 1'b1 big-endian
`ifndef APB_SUB_DEFINES_SVH
`define APB_SUB_DEFINES_SVH

// ----------------------------------------
// APB slot map
// ----------------------------------------
`define APB_SUB_NUM_SLOTS 9             // Peripheral windows on the bridge

`define APB_SUB_BASE_ADDR 32'h0080_0000 // Slot 0 start

// 64 KiB per slot, slot k at base + k*span
`define APB_SUB_SLOT_SPAN 32'h0001_0000

// ----------------------------------------
// Bus widths and byte order
// ----------------------------------------
`define APB_SUB_DATA_W 32               // AHB and APB data width

// Lane order of the byte strobe
// 1'b0 maps addr 00 to lane 0, 1'b1 maps addr 00 to lane 3
`define APB_SUB_BIG_ENDIAN 1'b0

`endif

// File: hw/apb_sub_pkg.sv
// Types shared by the bridge, the interrupt block and the clock gates
// Struct field order is fixed, the testbench packs the same layout
`default_nettype none

`include "apb_sub_defines.svh"

package apb_sub_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  typedef logic [31:0]                       addr_t;     // Byte address
  typedef logic [`APB_SUB_DATA_W-1:0]        data_t;
  typedef logic [`APB_SUB_DATA_W/8-1:0]      strb_t;     // One bit per byte lane
  typedef logic [`APB_SUB_NUM_SLOTS-1:0]     slot_sel_t; // One-hot psel
  typedef logic [17:0]                       irq_vec_t;  // System source vector

  // APB request, common to all slots
  typedef struct packed {
    addr_t paddr;
    logic  pwrite;
    data_t pwdata;
    strb_t pstrb;
    logic  penable;
  } apb_req_t;

  // APB response from one slot
  typedef struct packed {
    data_t prdata;
    logic  pready;
  } apb_rsp_t;

  typedef apb_rsp_t [`APB_SUB_NUM_SLOTS-1:0] apb_rsp_vec_t;

  // Incoming peripheral and MAC interrupt lines
  typedef struct packed {
    logic       dma;
    logic       spi;
    logic       uart1;
    logic       uart0;
    logic       gpio;
    logic [2:0] ttc;
    logic       pcm_wake;   // Wake-up from the power controller
    logic [3:0] macb;
  } irq_src_t;

  // Gate requests from the power controller, 1 stops the clock
  typedef struct packed {
    logic       smc;
    logic       uart;
    logic [3:0] macb;
  } gate_req_t;

  typedef enum logic [2:0] {
    IDLE,
    CAPTURE,  // Data phase, hwdata valid
    SETUP,
    ACCESS,
    ERR1,     // First ERROR cycle, hready low
    ERR2      // Second ERROR cycle, hready high
  } bridge_state_t;

endpackage

`default_nettype wire

// File: hw/apb_slot_decode.sv
// Combinational window compare over the slot map
// Overlapping windows are not supported, at most one select is high
`timescale 1ns/1ps
`default_nettype none

`include "apb_sub_defines.svh"

module apb_slot_decode (
  input  wire apb_sub_pkg::addr_t  i_addr,
  output apb_sub_pkg::slot_sel_t   o_slot_sel,
  output logic                     o_hit
);

  // ----------------------------------------
  // Per-slot window check
  // ----------------------------------------
  always_comb begin
    apb_sub_pkg::addr_t win_lo;
    apb_sub_pkg::addr_t win_hi;
    o_slot_sel = '0;
    for (int k = 0; k < `APB_SUB_NUM_SLOTS; k++) begin
      win_lo = `APB_SUB_BASE_ADDR + apb_sub_pkg::addr_t'(k) * `APB_SUB_SLOT_SPAN;
      win_hi = win_lo + `APB_SUB_SLOT_SPAN - 32'd1;    // Inclusive top
      o_slot_sel[k] = (i_addr >= win_lo) && (i_addr <= win_hi);
    end
  end

  // Miss below base or above last slot
  assign o_hit = |o_slot_sel;

endmodule

`default_nettype wire

// File: hw/ahb_apb_bridge.sv
// AHB-Lite slave to APB master, one transfer in flight
// Minimum four cycles per mapped transfer, no upper bound on pready wait
// Unmapped addresses get a two-cycle ERROR and no psel
`timescale 1ns/1ps
`default_nettype none

`include "apb_sub_defines.svh"

module ahb_apb_bridge (
  input  wire                             i_hclk,
  input  wire                             i_arst_n,
  // AHB-Lite slave side
  input  wire                             i_hsel,
  input  wire apb_sub_pkg::addr_t         i_haddr,
  input  wire logic [1:0]                 i_htrans,
  input  wire                             i_hwrite,
  input  wire apb_sub_pkg::data_t         i_hwdata,
  input  wire                             i_hready_in,
  output apb_sub_pkg::data_t              o_hrdata,
  output logic                            o_hready,
  output logic [1:0]                      o_hresp,
  // APB master side
  input  wire apb_sub_pkg::apb_rsp_vec_t  i_apb_rsp,
  output apb_sub_pkg::apb_req_t           o_apb_req,
  output apb_sub_pkg::slot_sel_t          o_psel
);

  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;
  localparam logic [1:0] hresp_okay    = 2'b00;
  localparam logic [1:0] hresp_error   = 2'b01;

  apb_sub_pkg::bridge_state_t state_q;
  apb_sub_pkg::bridge_state_t state_d;

  apb_sub_pkg::addr_t     paddr_q;      // Captured at address phase
  logic                   pwrite_q;
  apb_sub_pkg::data_t     pwdata_q;     // Captured in data phase
  apb_sub_pkg::data_t     hrdata_q;
  apb_sub_pkg::slot_sel_t psel_q;
  logic                   penable_q;

  logic                   addr_phase;   // Bridge can take a new address
  logic                   accept;
  apb_sub_pkg::addr_t     dec_addr;
  apb_sub_pkg::slot_sel_t dec_sel;
  logic                   dec_hit;
  apb_sub_pkg::data_t     rsp_prdata;   // Response of active slot
  logic                   rsp_pready;
  logic [1:0]             lane;
  apb_sub_pkg::strb_t     pstrb;

  // ----------------------------------------
  // AHB handshake
  // ----------------------------------------
  assign addr_phase = (state_q == apb_sub_pkg::IDLE) || (state_q == apb_sub_pkg::ERR2);
  assign o_hready   = addr_phase;     // Low through CAPTURE, SETUP, ACCESS, ERR1
  assign accept     = i_hsel && i_hready_in && o_hready &&
                      ((i_htrans == htrans_nonseq) || (i_htrans == htrans_seq));

  // ERROR spans both error states
  assign o_hresp = ((state_q == apb_sub_pkg::ERR1) || (state_q == apb_sub_pkg::ERR2)) ?
                   hresp_error : hresp_okay;

  // Live address for the miss check, registered address for the slot
  assign dec_addr = addr_phase ? i_haddr : paddr_q;

  apb_slot_decode u_slot_decode (
    .i_addr     (dec_addr),
    .o_slot_sel (dec_sel),
    .o_hit      (dec_hit)
  );

  // Only the selected slot contributes
  always_comb begin
    rsp_prdata = '0;
    rsp_pready = 1'b0;
    for (int k = 0; k < `APB_SUB_NUM_SLOTS; k++) begin
      if (psel_q[k]) begin
        rsp_prdata = rsp_prdata | i_apb_rsp[k].prdata;
        rsp_pready = rsp_pready | i_apb_rsp[k].pready;
      end
    end
  end

  // ----------------------------------------
  // Transfer FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      apb_sub_pkg::IDLE,
      apb_sub_pkg::ERR2: begin
        if (accept) begin
          state_d = dec_hit ? apb_sub_pkg::CAPTURE : apb_sub_pkg::ERR1;
        end else begin
          state_d = apb_sub_pkg::IDLE;
        end
      end
      apb_sub_pkg::CAPTURE: state_d = apb_sub_pkg::SETUP;
      apb_sub_pkg::SETUP:   state_d = apb_sub_pkg::ACCESS;
      apb_sub_pkg::ACCESS: begin
        if (rsp_pready) begin   // Else wait on slave
          state_d = apb_sub_pkg::IDLE;
        end
      end
      apb_sub_pkg::ERR1:    state_d = apb_sub_pkg::ERR2;
      default:              state_d = apb_sub_pkg::IDLE;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= apb_sub_pkg::IDLE;
      psel_q    <= '0;
      penable_q <= 1'b0;
    end else begin
      state_q <= state_d;
      case (state_q)
        apb_sub_pkg::CAPTURE: psel_q    <= dec_sel;  // Decoded from paddr_q
        apb_sub_pkg::SETUP:   penable_q <= 1'b1;
        apb_sub_pkg::ACCESS: begin
          if (rsp_pready) begin
            psel_q    <= '0;
            penable_q <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      paddr_q  <= i_haddr;
      pwrite_q <= i_hwrite;
    end
    if (state_q == apb_sub_pkg::CAPTURE) begin
      pwdata_q <= i_hwdata;     // hwdata valid one cycle after address
    end
    if ((state_q == apb_sub_pkg::ACCESS) && rsp_pready && !pwrite_q) begin
      hrdata_q <= rsp_prdata;
    end
  end

  // ----------------------------------------
  // Byte-lane strobe
  // ----------------------------------------
  // Byte-wide register slots, one lane per access
  assign lane  = `APB_SUB_BIG_ENDIAN ? ~paddr_q[1:0] : paddr_q[1:0];
  assign pstrb = apb_sub_pkg::strb_t'(1) << lane;

  assign o_apb_req = '{paddr:   paddr_q,
                       pwrite:  pwrite_q,
                       pwdata:  pwdata_q,
                       pstrb:   pstrb,
                       penable: penable_q};
  assign o_psel    = psel_q;
  assign o_hrdata  = hrdata_q;

endmodule

`default_nettype wire

// File: hw/irq_wake_detect.sv
// Interrupt source vector and wake-up event for the power controller
// Wake is one cycle late, inputs are taken as synchronous to i_hclk
`timescale 1ns/1ps
`default_nettype none

module irq_wake_detect (
  input  wire                         i_hclk,
  input  wire                         i_arst_n,
  input  wire apb_sub_pkg::irq_src_t  i_irq,
  input  wire                         i_isolate_mem,  // High in hibernation
  output apb_sub_pkg::irq_vec_t       o_irq_vec,
  output logic                        o_wake
);

  logic wake_d;

  // MACs on top, bits 13 and 11 to 8 reserved
  assign o_irq_vec = {i_irq.macb[0],
                      i_irq.macb[1],
                      i_irq.macb[2],
                      i_irq.macb[3],
                      1'b0,
                      i_irq.pcm_wake,       // Bit 12
                      4'b0000,
                      i_irq.ttc,            // Bits 7 to 5
                      i_irq.gpio,
                      i_irq.uart0,
                      i_irq.uart1,
                      i_irq.spi,
                      i_irq.dma};           // Bit 0

  // ----------------------------------------
  // Wake-up event
  // ----------------------------------------
  // Sleep wake on any source, hibernate wake on gpio only
  assign wake_d = ((|o_irq_vec) && !i_isolate_mem) || (i_isolate_mem && i_irq.gpio);

  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wake <= 1'b0;
    end else begin
      o_wake <= wake_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/srpg_clock_gates.sv
// Latch-based clock gates for the retention domains
// Enables follow a request change after the next low phase of i_hclk
// Scan mode forces every domain on, the latches themselves have no reset
`timescale 1ns/1ps
`default_nettype none

module srpg_clock_gates (
  input  wire                          i_hclk,
  input  wire apb_sub_pkg::gate_req_t  i_gate_req,
  input  wire                          i_scan_mode,
  output logic                         o_gclk_smc,
  output logic                         o_gclk_uart,
  output logic [3:0]                   o_macb_clk_en
);

  localparam int num_domains = $bits(apb_sub_pkg::gate_req_t);

  // Bit 5 smc, bit 4 uart, bits 3 to 0 macb
  logic [num_domains-1:0] gate_req;
  logic [num_domains-1:0] scan_gate;      // Enable before the latch
  logic [num_domains-1:0] latched_en;

  assign gate_req = i_gate_req;

  // ----------------------------------------
  // One gate per domain
  // ----------------------------------------
  for (genvar d = 0; d < num_domains; d++) begin : g_gate
    assign scan_gate[d] = i_scan_mode ? 1'b1 : ~gate_req[d];

    // Transparent while clock low, so the enable is stable in the high phase
    always_latch begin
      if (!i_hclk) begin
        latched_en[d] <= scan_gate[d];
      end
    end
  end

  // ----------------------------------------
  // Domain outputs
  // ----------------------------------------
  assign o_gclk_smc    = i_hclk & latched_en[5];  // Glitch free, enable held
  assign o_gclk_uart   = i_hclk & latched_en[4];

  // MAC domains gate locally, only the enable leaves
  assign o_macb_clk_en = latched_en[3:0];

endmodule

`default_nettype wire

// File: hw/apb_sub_top.sv
// Peripheral subsystem glue on a single AHB clock
// Peripherals sit outside, on the APB slot ports and interrupt inputs
// o_hready is meant to be fed back into i_hready_in on a single-slave bus
`timescale 1ns/1ps
`default_nettype none

module apb_sub_top (
  input  wire                             i_hclk,
  input  wire                             i_arst_n,
  // ----------------------------------------
  // AHB-Lite slave port
  // ----------------------------------------
  input  wire                             i_hsel,
  input  wire apb_sub_pkg::addr_t         i_haddr,
  input  wire logic [1:0]                 i_htrans,
  input  wire                             i_hwrite,
  input  wire apb_sub_pkg::data_t         i_hwdata,
  input  wire                             i_hready_in,
  output apb_sub_pkg::data_t              o_hrdata,
  output logic                            o_hready,
  output logic [1:0]                      o_hresp,
  // ----------------------------------------
  // APB master port, one psel per slot
  // ----------------------------------------
  input  wire apb_sub_pkg::apb_rsp_vec_t  i_apb_rsp,
  output apb_sub_pkg::apb_req_t           o_apb_req,
  output apb_sub_pkg::slot_sel_t          o_psel,
  // Interrupts and wake-up
  input  wire apb_sub_pkg::irq_src_t      i_irq,
  input  wire                             i_isolate_mem,
  output apb_sub_pkg::irq_vec_t           o_irq_vec,
  output logic                            o_wake,
  // Retention domain clocks
  input  wire apb_sub_pkg::gate_req_t     i_gate_req,
  input  wire                             i_scan_mode,    // Test mode, all clocks on
  output logic                            o_gclk_smc,
  output logic                            o_gclk_uart,
  output logic [3:0]                      o_macb_clk_en
);

  // AHB to APB path
  ahb_apb_bridge u_bridge (
    .i_hclk      (i_hclk),
    .i_arst_n    (i_arst_n),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hwdata    (i_hwdata),
    .i_hready_in (i_hready_in),
    .o_hrdata    (o_hrdata),
    .o_hready    (o_hready),
    .o_hresp     (o_hresp),
    .i_apb_rsp   (i_apb_rsp),
    .o_apb_req   (o_apb_req),
    .o_psel      (o_psel)
  );

  // Interrupt collection, wake goes to the power controller
  irq_wake_detect u_irq (
    .i_hclk        (i_hclk),
    .i_arst_n      (i_arst_n),
    .i_irq         (i_irq),
    .i_isolate_mem (i_isolate_mem),
    .o_irq_vec     (o_irq_vec),
    .o_wake        (o_wake)
  );

  srpg_clock_gates u_clk_gates (
    .i_hclk        (i_hclk),
    .i_gate_req    (i_gate_req),
    .i_scan_mode   (i_scan_mode),
    .o_gclk_smc    (o_gclk_smc),
    .o_gclk_uart   (o_gclk_uart),
    .o_macb_clk_en (o_macb_clk_en)
  );

endmodule

`default_nettype wire

// File: testbench/apb_slave_model.sv
// Behavioural APB slaves, one per slot, 16 words each
// Word index is paddr[5:2], higher offset bits alias onto the same words
// Slots 4 and 7 read zero with no wait, the others take i_wait per transfer
`timescale 1ns/1ps
`default_nettype none

`include "apb_sub_defines.svh"

module apb_slave_model (
  input  wire                             i_clk,
  input  wire                             i_arst_n,
  input  wire apb_sub_pkg::apb_req_t      i_req,
  input  wire apb_sub_pkg::slot_sel_t     i_psel,
  input  wire logic [1:0]                 i_wait,   // ACCESS waits, sampled in SETUP
  output apb_sub_pkg::apb_rsp_vec_t       o_rsp
);

  apb_sub_pkg::data_t mem [`APB_SUB_NUM_SLOTS][16];
  logic [1:0]         wait_q;                     // Remaining busy cycles
  logic [3:0]         word;

  assign word = i_req.paddr[5:2];

  function automatic logic quiet_slot(input int slot);
    return (slot == 4) || (slot == 7);
  endfunction

  always @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wait_q <= 2'd0;
      for (int k = 0; k < `APB_SUB_NUM_SLOTS; k++) begin
        for (int w = 0; w < 16; w++) begin
          mem[k][w] <= {16'hc0de, 8'(k), 8'(w)};  // Slot and word in every fill
        end
      end
    end else begin
      if (|i_psel && !i_req.penable) begin
        wait_q <= i_wait;                         // SETUP, arm the wait count
      end else if (|i_psel && (wait_q != 2'd0)) begin
        wait_q <= wait_q - 2'd1;
      end
      // Write lands on the completing ACCESS edge
      for (int k = 0; k < `APB_SUB_NUM_SLOTS; k++) begin
        if (i_psel[k] && i_req.penable && i_req.pwrite && (wait_q == 2'd0) && !quiet_slot(k)) begin
          mem[k][word] <= i_req.pwdata;
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < `APB_SUB_NUM_SLOTS; k++) begin
      o_rsp[k].prdata = quiet_slot(k) ? '0 : mem[k][word];
      o_rsp[k].pready = quiet_slot(k) ? 1'b1 : (wait_q == 2'd0);
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_apb_sub.sv
// Random AHB traffic, interrupt and clock gate stimulus against a testbench model
// Inputs change and outputs are sampled 1 ns after the rising edge of the clock
// The slave fill pattern is mirrored in the shadow, both key on slot and word
`timescale 1ns/1ps
`default_nettype none

`include "apb_sub_defines.svh"

module tb_apb_sub;

  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] resp_okay     = 2'b00;
  localparam logic [1:0] resp_error    = 2'b01;

  localparam int num_slots     = `APB_SUB_NUM_SLOTS;
  localparam int num_random    = 200;
  localparam int num_unmapped  = 40;
  localparam int num_strobe    = num_slots * 4;
  localparam int num_backpress = num_slots * 8;    // Write and read per wait count
  localparam int num_irq       = 60;
  localparam int num_gate      = 30;
  localparam int num_xfers     = num_random + num_unmapped + num_strobe + num_backpress;
  // 12 cycles per transfer at most, plus reset, irq and gate phases
  localparam int timeout_ns    = (num_xfers * 12 + num_irq + num_gate * 4 + 200) * 4;

  logic                      clk;
  logic                      arst_n;
  logic                      hsel;
  apb_sub_pkg::addr_t        haddr;
  logic [1:0]                htrans;
  logic                      hwrite;
  apb_sub_pkg::data_t        hwdata;
  logic                      hready_in;
  apb_sub_pkg::data_t        hrdata;
  logic                      hready;
  logic [1:0]                hresp;
  apb_sub_pkg::apb_rsp_vec_t apb_rsp;
  apb_sub_pkg::apb_req_t     apb_req;
  apb_sub_pkg::slot_sel_t    psel;
  apb_sub_pkg::irq_src_t     irq;
  logic                      isolate_mem;
  apb_sub_pkg::irq_vec_t     irq_vec;
  logic                      wake;
  apb_sub_pkg::gate_req_t    gate_req;
  logic                      scan_mode;
  logic                      gclk_smc;
  logic                      gclk_uart;
  logic [3:0]                macb_clk_en;
  logic [1:0]                wait_cycles;

  apb_sub_pkg::data_t shadow [num_slots][16];      // Expected slave contents
  int errors = 0;
  int xfers = 0;
  int smc_edges = 0;
  int uart_edges = 0;

  apb_sub_top dut (
    .i_hclk (clk), .i_arst_n (arst_n),
    .i_hsel (hsel), .i_haddr (haddr), .i_htrans (htrans), .i_hwrite (hwrite),
    .i_hwdata (hwdata), .i_hready_in (hready_in),
    .o_hrdata (hrdata), .o_hready (hready), .o_hresp (hresp),
    .i_apb_rsp (apb_rsp), .o_apb_req (apb_req), .o_psel (psel),
    .i_irq (irq), .i_isolate_mem (isolate_mem), .o_irq_vec (irq_vec), .o_wake (wake),
    .i_gate_req (gate_req), .i_scan_mode (scan_mode),
    .o_gclk_smc (gclk_smc), .o_gclk_uart (gclk_uart), .o_macb_clk_en (macb_clk_en)
  );

  apb_slave_model slaves (
    .i_clk (clk), .i_arst_n (arst_n), .i_req (apb_req), .i_psel (psel),
    .i_wait (wait_cycles), .o_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge gclk_smc) smc_edges++;
  always @(posedge gclk_uart) uart_edges++;

  // ----------------------------------------
  // Reporting and reference rules
  // ----------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic test_done(input int num, input string name, input int errs_before);
    $display("test %0d %s finished with %0d errors", num, name, errors - errs_before);
  endtask

  // Slot k covers base + k*span up to base + (k+1)*span - 1, -1 outside the map
  function automatic int expected_slot(input apb_sub_pkg::addr_t addr);
    longint offset;
    offset = longint'(addr) - longint'(`APB_SUB_BASE_ADDR);
    if ((offset < 0) || (offset >= longint'(num_slots) * longint'(`APB_SUB_SLOT_SPAN))) begin
      return -1;
    end
    return int'(offset / longint'(`APB_SUB_SLOT_SPAN));
  endfunction

  function automatic apb_sub_pkg::strb_t expected_strb(input logic [1:0] low_bits);
    if (`APB_SUB_BIG_ENDIAN) begin
      return 4'b1000 >> low_bits;
    end
    return 4'b0001 << low_bits;
  endfunction

  function automatic logic quiet_slot(input int slot);
    return (slot == 4) || (slot == 7);
  endfunction

  function automatic apb_sub_pkg::irq_vec_t expected_vec(input apb_sub_pkg::irq_src_t src);
    apb_sub_pkg::irq_vec_t v;
    v = '0;
    for (int m = 0; m < 4; m++) begin
      v[17 - m] = src.macb[m];                     // macb0 on bit 17
    end
    v[12]  = src.pcm_wake;
    v[7:5] = src.ttc;
    v[4]   = src.gpio;
    v[3]   = src.uart0;
    v[2]   = src.uart1;
    v[1]   = src.spi;
    v[0]   = src.dma;
    return v;
  endfunction

  // ----------------------------------------
  // AHB transfers
  // ----------------------------------------
  task automatic mapped_xfer(input apb_sub_pkg::addr_t addr, input logic write,
                             input apb_sub_pkg::data_t wdata, input logic [1:0] waits);
    int slot;
    int word;
    int lows;
    int setups;
    int exp_lows;
    apb_sub_pkg::slot_sel_t exp_sel;
    apb_sub_pkg::data_t     exp_rdata;
    slot      = expected_slot(addr);
    word      = int'(addr[5:2]);
    exp_sel   = '0;
    exp_sel[slot] = 1'b1;
    exp_lows  = quiet_slot(slot) ? 3 : 3 + int'(waits);  // CAPTURE, SETUP, ACCESS
    exp_rdata = quiet_slot(slot) ? '0 : shadow[slot][word];
    lows      = 0;
    setups    = 0;
    hsel        = 1'b1;
    haddr       = addr;
    htrans      = htrans_nonseq;
    hwrite      = write;
    wait_cycles = waits;
    @(posedge clk);
    #1;
    hsel   = 1'b0;
    htrans = htrans_idle;
    hwdata = wdata;                                // Data phase
    while (!hready) begin
      lows++;
      if (hresp !== resp_okay) report_mismatch("o_hresp", hresp, resp_okay);
      if (|psel && !apb_req.penable) begin         // SETUP cycle
        setups++;
        if (psel !== exp_sel) report_mismatch("o_psel", psel, exp_sel);
        if (apb_req.pstrb !== expected_strb(addr[1:0])) begin
          report_mismatch("pstrb", apb_req.pstrb, expected_strb(addr[1:0]));
        end
        if (apb_req.paddr !== addr) report_mismatch("paddr", apb_req.paddr, addr);
        if (apb_req.pwrite !== write) report_mismatch("pwrite", apb_req.pwrite, write);
        if (write && (apb_req.pwdata !== wdata)) report_mismatch("pwdata", apb_req.pwdata, wdata);
      end
      @(posedge clk);
      #1;
    end
    if (setups != 1) report_failure($sformatf("%0d SETUP cycles at address %h", setups, addr));
    if (lows != exp_lows) report_mismatch("o_hready low cycles", lows, exp_lows);
    if (hresp !== resp_okay) report_mismatch("o_hresp", hresp, resp_okay);
    if (!write && (hrdata !== exp_rdata)) report_mismatch("o_hrdata", hrdata, exp_rdata);
    if (write && !quiet_slot(slot)) begin
      shadow[slot][word] = wdata;
    end
    xfers++;
  endtask

  // Two ERROR cycles, first with hready low, no psel at any time
  task automatic unmapped_xfer(input apb_sub_pkg::addr_t addr, input logic write);
    hsel   = 1'b1;
    haddr  = addr;
    htrans = htrans_nonseq;
    hwrite = write;
    @(posedge clk);
    #1;
    hsel   = 1'b0;
    htrans = htrans_idle;
    hwdata = $urandom;
    if (hready !== 1'b0) report_mismatch("o_hready", hready, 1'b0);
    if (hresp !== resp_error) report_mismatch("o_hresp", hresp, resp_error);
    if (psel !== '0) report_mismatch("o_psel", psel, '0);
    @(posedge clk);
    #1;
    if (hready !== 1'b1) report_mismatch("o_hready", hready, 1'b1);
    if (hresp !== resp_error) report_mismatch("o_hresp", hresp, resp_error);
    if (psel !== '0) report_mismatch("o_psel", psel, '0);
    xfers++;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int                    errs_before;
    int                    slot;
    int                    smc_before;
    int                    uart_before;
    logic [31:0]           rnd;
    apb_sub_pkg::addr_t    addr;
    apb_sub_pkg::irq_vec_t exp_vec;
    logic                  exp_wake;
    logic [3:0]            exp_en;
    void'($urandom(78200));
    arst_n      = 1'b0;
    hsel        = 1'b0;
    haddr       = '0;
    htrans      = htrans_idle;
    hwrite      = 1'b0;
    hwdata      = '0;
    hready_in   = 1'b1;                            // Single slave, bus always ready
    irq         = '0;
    isolate_mem = 1'b0;
    gate_req    = '0;
    scan_mode   = 1'b0;
    wait_cycles = 2'd0;
    for (int k = 0; k < num_slots; k++) begin
      for (int w = 0; w < 16; w++) begin
        shadow[k][w] = {16'hc0de, 8'(k), 8'(w)};
      end
    end
    repeat (3) @(posedge clk);
    #1;
    errs_before = errors;
    if (hready !== 1'b1) report_mismatch("o_hready", hready, 1'b1);
    if (hresp !== resp_okay) report_mismatch("o_hresp", hresp, resp_okay);
    if (psel !== '0) report_mismatch("o_psel", psel, '0);
    if (apb_req.penable !== 1'b0) report_mismatch("penable", apb_req.penable, 1'b0);
    if (wake !== 1'b0) report_mismatch("o_wake", wake, 1'b0);
    arst_n = 1'b1;
    test_done(0, "reset values", errs_before);

    errs_before = errors;
    for (int i = 0; i < num_random; i++) begin
      slot = $urandom_range(0, num_slots - 1);
      addr = `APB_SUB_BASE_ADDR + slot * `APB_SUB_SLOT_SPAN +
             $urandom_range(0, `APB_SUB_SLOT_SPAN - 1);
      mapped_xfer(addr, $urandom_range(0, 1), $urandom, $urandom_range(0, 3));
    end
    test_done(1, "random reads and writes", errs_before);

    errs_before = errors;
    for (int i = 0; i < num_unmapped; i++) begin
      if (i % 2 == 0) begin
        addr = $urandom_range(`APB_SUB_BASE_ADDR - 1, 0);
      end else begin
        addr = $urandom_range(32'hffff_ffff,
                              `APB_SUB_BASE_ADDR + num_slots * `APB_SUB_SLOT_SPAN);
      end
      unmapped_xfer(addr, $urandom_range(0, 1));
    end
    test_done(2, "unmapped addresses", errs_before);

    // Lowest and highest words of every window, every lane
    errs_before = errors;
    for (int k = 0; k < num_slots; k++) begin
      for (int lane = 0; lane < 4; lane++) begin
        addr = `APB_SUB_BASE_ADDR + k * `APB_SUB_SLOT_SPAN + lane +
               ((lane < 2) ? 0 : `APB_SUB_SLOT_SPAN - 4);
        mapped_xfer(addr, lane[0], $urandom, 2'd0);
      end
    end
    test_done(3, "strobe and decode", errs_before);

    errs_before = errors;
    for (int k = 0; k < num_slots; k++) begin
      for (int w = 0; w < 4; w++) begin
        addr = `APB_SUB_BASE_ADDR + k * `APB_SUB_SLOT_SPAN + 4 * $urandom_range(0, 15);
        mapped_xfer(addr, 1'b1, $urandom, w[1:0]);
        mapped_xfer(addr, 1'b0, '0, w[1:0]);
      end
    end
    test_done(4, "back-pressure", errs_before);

    errs_before = errors;
    for (int i = 0; i < num_irq; i++) begin
      rnd = (i % 4 == 0) ? '0 : ($urandom & $urandom);   // Sparse, some all quiet
      irq = rnd[$bits(apb_sub_pkg::irq_src_t)-1:0];
      isolate_mem = $urandom_range(0, 1);
      exp_vec  = expected_vec(irq);
      exp_wake = isolate_mem ? irq.gpio : (exp_vec != '0);
      #1;
      if (irq_vec !== exp_vec) report_mismatch("o_irq_vec", irq_vec, exp_vec);
      @(posedge clk);
      #1;
      if (wake !== exp_wake) report_mismatch("o_wake", wake, exp_wake);
    end
    irq = '0;
    isolate_mem = 1'b0;
    test_done(5, "interrupts and wake", errs_before);

    // Last five rounds in scan mode
    errs_before = errors;
    for (int i = 0; i < num_gate; i++) begin
      rnd       = $urandom;
      gate_req  = rnd[5:0];
      scan_mode = (i >= num_gate - 5);
      @(posedge clk);                              // Low phase passes first
      #1;
      exp_en = scan_mode ? 4'hf : ~gate_req.macb;
      if (macb_clk_en !== exp_en) report_mismatch("o_macb_clk_en", macb_clk_en, exp_en);
      smc_before  = smc_edges;
      uart_before = uart_edges;
      repeat (2) @(posedge clk);
      #1;
      if (smc_edges - smc_before != ((scan_mode || !gate_req.smc) ? 2 : 0)) begin
        report_mismatch("o_gclk_smc edges", smc_edges - smc_before,
                        (scan_mode || !gate_req.smc) ? 2 : 0);
      end
      if (uart_edges - uart_before != ((scan_mode || !gate_req.uart) ? 2 : 0)) begin
        report_mismatch("o_gclk_uart edges", uart_edges - uart_before,
                        (scan_mode || !gate_req.uart) ? 2 : 0);
      end
    end
    test_done(6, "clock gates", errs_before);

    $display("7 tests, %0d transfers, %0d errors", xfers, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog for a transfer that never completes
  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns, the run did not complete", timeout_ns);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: apb_sub.f
+incdir+hw
hw/apb_sub_pkg.sv
hw/apb_slot_decode.sv
hw/ahb_apb_bridge.sv
hw/irq_wake_detect.sv
hw/srpg_clock_gates.sv
hw/apb_sub_top.sv
testbench/apb_slave_model.sv
testbench/tb_apb_sub.sv

// File: Bender.yml
package:
  name: apb_sub

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/apb_sub_pkg.sv
      - hw/apb_slot_decode.sv
      - hw/ahb_apb_bridge.sv
      - hw/irq_wake_detect.sv
      - hw/srpg_clock_gates.sv
      - hw/apb_sub_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/apb_slave_model.sv
      - testbench/tb_apb_sub.sv
